//--- Makefile
# Verilator build and run of the APB ALU testbench

SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes
obj_dir/Vtb_alu_top: tb.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_alu_top \
		-f tb.f -o Vtb_alu_top

# Pass or fail is decided from the log, not from the simulator's exit code
run: obj_dir/Vtb_alu_top
	./obj_dir/Vtb_alu_top | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- alu_apb_regs.sv
// APB register block holding the operands, decoding accesses and issuing ALU commands
`default_nettype none

module alu_apb_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  alu_pkg::apb_req_t    req,
  output alu_pkg::apb_rsp_t    rsp,
  input  logic                 busy,
  input  alu_pkg::alu_result_t result,
  output logic                 start,
  output alu_pkg::alu_cmd_t    cmd
);
  import alu_pkg::*;

  logic [DATA_W-1:0] a_q;
  logic [DATA_W-1:0] b_q;
  alu_cmd_t          cmd_q;
  logic              start_q;

  logic              access;
  logic              wr_access;
  logic              rd_access;
  logic              addr_hit;
  logic              addr_ro;
  logic              is_cmd_wr;
  alu_op_e           wr_op;
  logic              cmd_refused;
  logic              err;
  logic              wr_ok;
  logic [DATA_W-1:0] rd_mux;

  // PREADY is tied high, so every access phase completes the transfer
  assign access    = req.psel & req.penable;
  assign wr_access = access & req.pwrite;
  assign rd_access = access & ~req.pwrite;

  // Only the low two bits of a command write carry the opcode
  assign wr_op = alu_op_e'(req.pwdata[1:0]);

  // Address decode and read data mux
  always_comb
  begin
    addr_hit = 1'b1;
    addr_ro  = 1'b0;
    rd_mux   = '0;
    case (req.paddr)
      REG_A:   rd_mux = a_q;
      REG_B:   rd_mux = b_q;
      REG_CMD: rd_mux = {{(DATA_W-2){1'b0}}, cmd_q.op};
      REG_RESULT:
      begin
        rd_mux  = result.value;
        addr_ro = 1'b1;
      end
      REG_STATUS:
      begin
        rd_mux[STATUS_BUSY]  = busy;
        rd_mux[STATUS_ZERO]  = result.zero;
        rd_mux[STATUS_CARRY] = result.carry;
        addr_ro              = 1'b1;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  // A command is refused for the reserved opcode or while one is still in flight.
  // The start cycle counts as in flight because busy only rises one edge later
  assign is_cmd_wr   = wr_access & (req.paddr == REG_CMD);
  assign cmd_refused = is_cmd_wr & ((wr_op == OP_RSVD) | busy | start_q);

  assign err   = access & (~addr_hit | (req.pwrite & addr_ro) | cmd_refused);
  assign wr_ok = wr_access & ~err;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      a_q     <= '0;
      b_q     <= '0;
      cmd_q   <= '0;
      start_q <= 1'b0;
    end
    else
    begin
      // Start is a single cycle pulse
      start_q <= 1'b0;
      if (wr_ok && req.paddr == REG_A)
      begin
        a_q <= req.pwdata;
      end
      else if (wr_ok && req.paddr == REG_B)
      begin
        b_q <= req.pwdata;
      end
      else if (wr_ok && is_cmd_wr)
      begin
        // Snapshot the operands so later operand writes cannot disturb a multiply
        cmd_q.op <= wr_op;
        cmd_q.a  <= a_q;
        cmd_q.b  <= b_q;
        start_q  <= 1'b1;
      end
    end
  end

  assign rsp = '{prdata: (rd_access ? rd_mux : '0), pready: 1'b1, pslverr: err};

  assign start = start_q;
  assign cmd   = cmd_q;

endmodule

`default_nettype wire

//--- alu_arith_unit.sv
// Shared adder, result selection, flag generation and the registered ALU result
`default_nettype none

module alu_arith_unit (
  input  logic                         clk,
  input  logic                         reset,
  input  alu_pkg::alu_cmd_t            cmd,
  input  logic [2*alu_pkg::DATA_W-1:0] product,
  input  logic                         load,
  output alu_pkg::alu_result_t         result
);
  import alu_pkg::*;

  logic              sub;
  logic [DATA_W-1:0] b_operand;
  logic [DATA_W:0]   sum;
  logic [DATA_W-1:0] next_value;
  logic              next_carry;
  alu_result_t       result_q;

  // Subtract is a + ~b + 1 through the same adder
  assign sub       = (cmd.op == OP_SUB);
  assign b_operand = sub ? ~cmd.b : cmd.b;
  assign sum       = {1'b0, cmd.a} + {1'b0, b_operand} + (DATA_W + 1)'(sub);

  always_comb
  begin
    case (cmd.op)
      OP_MUL:
      begin
        // Carry reports that the product does not fit in one word
        next_value = product[DATA_W-1:0];
        next_carry = |product[2*DATA_W-1:DATA_W];
      end
      default:
      begin
        // Carry out on add, and no borrow on subtract
        next_value = sum[DATA_W-1:0];
        next_carry = sum[DATA_W];
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      result_q <= '0;
    end
    else if (load)
    begin
      result_q.value <= next_value;
      result_q.zero  <= (next_value == '0);
      result_q.carry <= next_carry;
    end
  end

  assign result = result_q;

endmodule

`default_nettype wire

//--- alu_control_fsm.sv
// Controller FSM that sequences single cycle add/sub and the nibble-serial multiply
`default_nettype none

module alu_control_fsm (
  input  logic             clk,
  input  logic             reset,
  input  logic             start,
  input  alu_pkg::alu_op_e op,
  input  logic             last_step,
  output logic             busy,
  output logic             mul_step,
  output logic             count_clear,
  output logic             load_result
);
  import alu_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  always_comb
  begin
    state_d     = state_q;
    mul_step    = 1'b0;
    count_clear = 1'b0;
    load_result = 1'b0;
    case (state_q)
      ST_IDLE:
      begin
        if (start)
        begin
          // Multiply handles nibble 0 in the start cycle itself
          if (op == OP_MUL)
          begin
            mul_step = 1'b1;
            state_d  = ST_MUL;
          end
          else
          begin
            // Add and subtract load straight away and stay idle
            load_result = 1'b1;
          end
        end
      end
      ST_MUL:
      begin
        mul_step = 1'b1;
        if (last_step)
        begin
          state_d = ST_DONE;
        end
      end
      ST_DONE:
      begin
        // Accumulator is complete, so capture it and rewind the step counter
        load_result = 1'b1;
        count_clear = 1'b1;
        state_d     = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Busy covers the remaining steps and the load cycle of a multiply
  assign busy = (state_q != ST_IDLE);

endmodule

`default_nettype wire

//--- alu_mul_datapath.sv
// Nibble-serial shift-and-add multiplier with a double-width accumulator
`default_nettype none

module alu_mul_datapath #(
  parameter  int NIBBLE_WIDTH = 4,
  localparam int STEPS        = alu_pkg::DATA_W / NIBBLE_WIDTH,
  localparam int IDX_W        = $clog2(STEPS)
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        start,
  input  alu_pkg::alu_cmd_t           cmd,
  input  logic                        step,
  input  logic [IDX_W-1:0]            index,
  output logic [2*alu_pkg::DATA_W-1:0] product
);
  import alu_pkg::*;

  localparam int PROD_W = 2 * DATA_W;

  int                      shift;
  logic [NIBBLE_WIDTH-1:0] slice;
  logic [PROD_W-1:0]       partial;
  logic [PROD_W-1:0]       acc_base;
  logic [PROD_W-1:0]       acc_q;

  // Bit position of the selected nibble, also the weight of its partial product
  assign shift = int'(index) * NIBBLE_WIDTH;

  // Current slice of the multiplier operand
  assign slice = NIBBLE_WIDTH'(cmd.b >> shift);

  // Multiplicand times one nibble, moved to the nibble's weight.
  // The widest case still fits in PROD_W bits
  assign partial = (PROD_W'(cmd.a) * PROD_W'(slice)) << shift;

  // The first step coincides with start, so it accumulates onto a cleared value
  assign acc_base = start ? '0 : acc_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      acc_q <= '0;
    end
    else if (step)
    begin
      acc_q <= acc_base + partial;
    end
    else if (start)
    begin
      // Add and subtract starts also clear the stale product
      acc_q <= '0;
    end
  end

  assign product = acc_q;

endmodule

`default_nettype wire

//--- alu_nibble_counter.sv
// Step counter that selects the current multiplier nibble and flags the final one
`default_nettype none

module alu_nibble_counter #(
  parameter  int NIBBLE_WIDTH = 4,
  localparam int STEPS        = alu_pkg::DATA_W / NIBBLE_WIDTH,
  localparam int IDX_W        = $clog2(STEPS)
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             clear,
  input  logic             enable,
  output logic [IDX_W-1:0] index,
  output logic             last_step
);

  logic [IDX_W-1:0] index_q;

  // Final slice is the most significant nibble of the multiplier
  assign last_step = (index_q == IDX_W'(STEPS - 1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      index_q <= '0;
    end
    else if (clear)
    begin
      index_q <= '0;
    end
    else if (enable)
    begin
      // Wraps back to nibble 0 after the last step
      index_q <= last_step ? '0 : index_q + 1'b1;
    end
  end

  assign index = index_q;

endmodule

`default_nettype wire

//--- alu_pkg.sv
// Shared word width, opcodes, FSM states, bus structs and register map of the APB ALU
`default_nettype none

package alu_pkg;

  // One data word, fixed by the APB data bus
  localparam int DATA_W = 32;

  // Width of the decoded APB address field
  localparam int ADDR_W = 5;

  // Opcode encodings as written to the command register
  typedef enum logic [1:0] {
    OP_ADD  = 2'b00,
    OP_SUB  = 2'b01,
    OP_MUL  = 2'b10,
    OP_RSVD = 2'b11
  } alu_op_e;

  // Controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MUL,
    ST_DONE
  } ctrl_state_e;

  // APB request as seen by the target, driven by the requester
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  // APB response driven back by the target
  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Command snapshot taken when an operation is accepted
  typedef struct packed {
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } alu_cmd_t;

  // Registered result with its flags
  typedef struct packed {
    logic [DATA_W-1:0] value;
    logic              zero;
    logic              carry;
  } alu_result_t;

  // Register offsets in the APB window
  localparam logic [ADDR_W-1:0] REG_A      = 5'h00;
  localparam logic [ADDR_W-1:0] REG_B      = 5'h04;
  localparam logic [ADDR_W-1:0] REG_CMD    = 5'h08;
  localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C;
  localparam logic [ADDR_W-1:0] REG_STATUS = 5'h10;

  // Bit positions inside the status register
  localparam int STATUS_BUSY  = 0;
  localparam int STATUS_ZERO  = 1;
  localparam int STATUS_CARRY = 2;

endpackage

`default_nettype wire

//--- alu_top.sv
// Top level of the APB arithmetic coprocessor, wiring registers, control and datapath
`default_nettype none

module alu_top #(
  parameter  int NIBBLE_WIDTH = 4,
  localparam int IDX_W        = $clog2(alu_pkg::DATA_W / NIBBLE_WIDTH)
) (
  input  logic              clk,
  input  logic              reset,
  input  alu_pkg::apb_req_t req,
  output alu_pkg::apb_rsp_t rsp
);
  import alu_pkg::*;

  logic                start;
  alu_cmd_t            cmd;
  logic                busy;
  logic                mul_step;
  logic                count_clear;
  logic                load_result;
  logic                last_step;
  logic [IDX_W-1:0]    index;
  logic [2*DATA_W-1:0] product;
  alu_result_t         result;

  alu_apb_regs regs_i (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .rsp    (rsp),
    .busy   (busy),
    .result (result),
    .start  (start),
    .cmd    (cmd)
  );

  alu_control_fsm ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .op          (cmd.op),
    .last_step   (last_step),
    .busy        (busy),
    .mul_step    (mul_step),
    .count_clear (count_clear),
    .load_result (load_result)
  );

  // The counter advances on the same steps that feed the multiplier
  alu_nibble_counter #(.NIBBLE_WIDTH(NIBBLE_WIDTH)) counter_i (
    .clk       (clk),
    .reset     (reset),
    .clear     (count_clear),
    .enable    (mul_step),
    .index     (index),
    .last_step (last_step)
  );

  alu_mul_datapath #(.NIBBLE_WIDTH(NIBBLE_WIDTH)) mul_i (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .cmd     (cmd),
    .step    (mul_step),
    .index   (index),
    .product (product)
  );

  alu_arith_unit arith_i (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .product (product),
    .load    (load_result),
    .result  (result)
  );

endmodule

`default_nettype wire

//--- tb.f
alu_pkg.sv
alu_apb_regs.sv
alu_control_fsm.sv
alu_nibble_counter.sv
alu_mul_datapath.sv
alu_arith_unit.sv
alu_top.sv
tb_alu_top.sv

//--- tb_alu_top.sv
// Self-checking testbench for the APB ALU with a reference model, APB tasks and a timeout
`default_nettype none

module tb_alu_top;
  timeunit 1ns;
  timeprecision 1ps;
  import alu_pkg::*;

  // Each operation needs at most about 30 cycles of APB traffic and polling
  localparam int TIMEOUT_CYCLES = 200 * 30;
  localparam logic [DATA_W-1:0] ALL_ONES = {DATA_W{1'b1}};

  logic        clk;
  logic        reset;
  apb_req_t    req;
  apb_rsp_t    rsp;
  int          cycles;
  alu_cmd_t    sent_q[$];
  alu_result_t got_q[$];

  alu_top alu_top_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .rsp   (rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Prints the cause, then the fail message, and stops the run
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_rsp(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_result(input string name, input alu_result_t got,
                              input alu_result_t exp);
    if (got !== exp)
      abort_run($sformatf("MISMATCH %s: got value %h zero %h carry %h, expected %h %h %h",
                          name, got.value, got.zero, got.carry,
                          exp.value, exp.zero, exp.carry));
  endtask

  // Expected result from the flag rules: carry out, no borrow, or a nonzero upper half
  function automatic alu_result_t ref_alu(input alu_cmd_t c);
    logic [2*DATA_W-1:0] wide;
    alu_result_t         r;
    case (c.op)
      OP_ADD:
      begin
        wide    = (2*DATA_W)'(c.a) + (2*DATA_W)'(c.b);
        r.value = wide[DATA_W-1:0];
        r.carry = wide[DATA_W];
      end
      OP_SUB:
      begin
        r.value = c.a - c.b;
        r.carry = (c.a >= c.b);
      end
      default:
      begin
        wide    = (2*DATA_W)'(c.a) * (2*DATA_W)'(c.b);
        r.value = wide[DATA_W-1:0];
        r.carry = (wide[2*DATA_W-1:DATA_W] != '0);
      end
    endcase
    r.zero = (r.value == '0);
    return r;
  endfunction

  function automatic alu_cmd_t make_cmd(input alu_op_e op, input logic [DATA_W-1:0] a,
                                        input logic [DATA_W-1:0] b);
    alu_cmd_t c;
    c.op = op;
    c.a  = a;
    c.b  = b;
    return c;
  endfunction

  // Setup cycle, then access cycle; the response is sampled mid access cycle
  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err);
    @(posedge clk);
    req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    req.penable <= 1'b1;
    @(negedge clk);
    err = rsp.pslverr;
    check_rsp("pready on write", rsp.pready, 1'b1);
    @(posedge clk);
    req <= '0;
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    @(posedge clk);
    req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(posedge clk);
    req.penable <= 1'b1;
    @(negedge clk);
    data = rsp.prdata;
    err  = rsp.pslverr;
    check_rsp("pready on read", rsp.pready, 1'b1);
    @(posedge clk);
    req <= '0;
  endtask

  task automatic write_ok(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic err;
    apb_write(addr, data, err);
    check_rsp($sformatf("pslverr on write to %h", addr), err, 1'b0);
  endtask

  task automatic read_ok(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    logic err;
    apb_read(addr, data, err);
    check_rsp($sformatf("pslverr on read of %h", addr), err, 1'b0);
  endtask

  // Software view of completion, polling until the busy bit clears
  task automatic wait_idle();
    logic [DATA_W-1:0] st;
    read_ok(REG_STATUS, st);
    while (st[STATUS_BUSY])
      read_ok(REG_STATUS, st);
  endtask

  // Result word and status flags put back together as one result
  task automatic read_result(output alu_result_t r);
    logic [DATA_W-1:0] st;
    read_ok(REG_RESULT, r.value);
    read_ok(REG_STATUS, st);
    r.zero  = st[STATUS_ZERO];
    r.carry = st[STATUS_CARRY];
  endtask

  task automatic send_result(input alu_cmd_t c, input alu_result_t got);
    sent_q.push_back(c);
    got_q.push_back(got);
  endtask

  task automatic run_op(input alu_cmd_t c);
    alu_result_t got;
    write_ok(REG_A, c.a);
    write_ok(REG_B, c.b);
    write_ok(REG_CMD, DATA_W'(c.op));
    wait_idle();
    read_result(got);
    send_result(c, got);
  endtask

  // Compare process, pairing every observed result with the reference model
  initial
  begin
    alu_cmd_t    c;
    alu_result_t got;
    forever
    begin
      @(negedge clk);
      while (got_q.size() != 0)
      begin
        c   = sent_q.pop_front();
        got = got_q.pop_front();
        check_result($sformatf("result of %s a %h b %h", c.op.name(), c.a, c.b),
                     got, ref_alu(c));
      end
    end
  end

  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge clk);
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
        abort_run($sformatf("Timeout after %0d cycles without finishing the tests", cycles));
    end
  end

  initial
  begin
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] saved_result;
    logic [DATA_W-1:0] saved_status;
    logic              err;
    alu_cmd_t          c;
    alu_result_t       got;
    reset = 1'b1;
    req   = '0;
    void'($urandom(32'h02640bc7));
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Every register reads zero out of reset
    read_ok(REG_A, word);
    check_word("A after reset", word, '0);
    read_ok(REG_B, word);
    check_word("B after reset", word, '0);
    read_ok(REG_CMD, word);
    check_word("CMD after reset", word, '0);
    read_ok(REG_RESULT, word);
    check_word("RESULT after reset", word, '0);
    read_ok(REG_STATUS, word);
    check_word("STATUS after reset", word, '0);

    // Operands come back as written
    a = $urandom();
    b = $urandom();
    write_ok(REG_A, a);
    write_ok(REG_B, b);
    read_ok(REG_A, word);
    check_word("A readback", word, a);
    read_ok(REG_B, word);
    check_word("B readback", word, b);

    // Add and subtract corners first, then random operands
    run_op(make_cmd(OP_SUB, '0, '0));
    run_op(make_cmd(OP_ADD, ALL_ONES, 32'd1));
    run_op(make_cmd(OP_SUB, '0, 32'd1));
    for (int i = 0; i < 80; i++)
      run_op(make_cmd(($urandom() & 1) ? OP_SUB : OP_ADD, $urandom(), $urandom()));

    // Multiply corners, then random operands, half of them small enough not to overflow
    run_op(make_cmd(OP_MUL, '0, $urandom()));
    run_op(make_cmd(OP_MUL, $urandom(), '0));
    run_op(make_cmd(OP_MUL, ALL_ONES, ALL_ONES));
    for (int i = 0; i < 80; i++)
    begin
      a = $urandom();
      b = $urandom();
      if (i % 2 == 1)
      begin
        a = a & 32'h0000_FFFF;
        b = b & 32'h0000_FFFF;
      end
      run_op(make_cmd(OP_MUL, a, b));
    end

    // A second command during a multiply is refused and the first one runs on untouched
    c = make_cmd(OP_MUL, $urandom(), $urandom());
    write_ok(REG_A, c.a);
    write_ok(REG_B, c.b);
    write_ok(REG_CMD, DATA_W'(OP_MUL));
    read_ok(REG_STATUS, word);
    check_word("STATUS busy during multiply", word & 32'h1, 32'h1);
    apb_write(REG_CMD, DATA_W'(OP_ADD), err);
    check_rsp("pslverr on command while busy", err, 1'b1);
    write_ok(REG_A, ~c.a);
    wait_idle();
    read_result(got);
    send_result(c, got);

    // Refused accesses leave the result and status alone
    read_ok(REG_RESULT, saved_result);
    read_ok(REG_STATUS, saved_status);
    apb_write(REG_CMD, DATA_W'(OP_RSVD), err);
    check_rsp("pslverr on reserved opcode", err, 1'b1);
    apb_write(5'h14, $urandom(), err);
    check_rsp("pslverr on unmapped write", err, 1'b1);
    apb_read(5'h1C, word, err);
    check_rsp("pslverr on unmapped read", err, 1'b1);
    apb_write(REG_RESULT, $urandom(), err);
    check_rsp("pslverr on RESULT write", err, 1'b1);
    apb_write(REG_STATUS, ALL_ONES, err);
    check_rsp("pslverr on STATUS write", err, 1'b1);
    read_ok(REG_RESULT, word);
    check_word("RESULT after refused accesses", word, saved_result);
    read_ok(REG_STATUS, word);
    check_word("STATUS after refused accesses", word, saved_status);

    // Let the compare process drain what is left
    while (got_q.size() != 0)
      @(posedge clk);
    @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire
